// File: Bender.yml
package:
  name: cpu_core

export_include_dirs:
  - common

sources:
  - files:
      - common/isa_pkg.sv
      - common/core_ctrl_pkg.sv
      - datapath/alu.sv
      - datapath/register_file.sv
      - datapath/datapath.sv
      - control/control_unit.sv
      - src/cpu_top.sv
  - target: test
    files:
      - bench/control_asserts.sv
      - bench/cpu_tb.sv

// File: all.f
+incdir+common
common/isa_pkg.sv
common/core_ctrl_pkg.sv
datapath/alu.sv
datapath/register_file.sv
datapath/datapath.sv
control/control_unit.sv
src/cpu_top.sv
bench/control_asserts.sv
bench/cpu_tb.sv

// File: bench/control_asserts.sv
module control_asserts (
    input logic                  clock,
    input logic                  rst_n,
    input core_ctrl_pkg::phase_e phase,
    input core_ctrl_pkg::ctrl_t  ctrl,
    input logic                  halted
);
    timeunit 1ns;
    timeprecision 1ps;
    import core_ctrl_pkg::*;

    mem_write_phase: assert property (@(posedge clock) disable iff (!rst_n)
        ctrl.mem_write |-> phase == ph_memory)
        else $error("mem_write high outside the memory phase");

    rf_write_phase: assert property (@(posedge clock) disable iff (!rst_n)
        ctrl.rf_write |-> phase == ph_write_back)
        else $error("rf_write high outside the write-back phase");

    phase_legal: assert property (@(posedge clock) disable iff (!rst_n)
        phase inside {ph_fetch, ph_reg_read, ph_execute, ph_memory, ph_write_back})
        else $error("phase register holds an illegal value");

    // only reset clears halted
    halted_sticky: assert property (@(posedge clock) disable iff (!rst_n)
        halted |=> halted)
        else $error("halted fell without reset");

endmodule

bind control_unit control_asserts u_control_asserts (
    .clock  (clock),
    .rst_n  (rst_n),
    .phase  (phase),
    .ctrl   (ctrl),
    .halted (halted)
);

// File: bench/cpu_tb.sv
`include "cpu_params.svh"

module cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import isa_pkg::*;

    localparam int W = `CPU_DATA_W;
    localparam logic [W-1:0] marker_skip  = 32'h5a5a_0001;
    localparam logic [W-1:0] marker_taken = 32'ha5a5_0002;
    localparam logic [W-1:0] halt_word    = {op_halt, 27'd0};

    logic         clock;
    logic         rst_n;
    logic [W-1:0] mem_rdata;
    logic [W-1:0] mem_addr;
    logic [W-1:0] mem_wdata;
    logic         mem_read;
    logic         mem_write;
    logic         halted;
    logic [W-1:0] mem [256];
    int           error_count;
    int           check_count;
    int           cycle_count;
    int           instr_budget;
    int           seed_value;

    cpu_top u_dut (
        .clock     (clock),
        .rst_n     (rst_n),
        .mem_rdata (mem_rdata),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .halted    (halted)
    );

    always #10 clock = ~clock;

    assign mem_rdata = mem[mem_addr[7:0]];     // word addressed, no wait states

    always @(posedge clock)
    begin
        if (mem_write)
            mem[mem_addr[7:0]] <= mem_wdata;
    end

    // five cycles per instruction plus slack for the reset pulses
    always @(posedge clock)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count > 5 * instr_budget + 100)
        begin
            $display("timeout after %0d cycles, the processor never halted", cycle_count);
            $display("*** FAILED ***");
            $finish;
        end
    end

    function automatic logic [W-1:0] fill_word(input logic [7:0] addr);
        return {24'hbad000, addr};             // unused opcode 23
    endfunction

    function automatic logic [W-1:0] encode_reg(input opcode_e op, input logic [3:0] ra,
                                                input logic [3:0] rb, input logic [3:0] rc);
        return {op, ra, rb, rc, 15'd0};
    endfunction

    function automatic logic [W-1:0] encode_imm(input opcode_e op, input logic [3:0] ra,
                                                input logic [3:0] rb, input logic [18:0] imm);
        return {op, ra, rb, imm};
    endfunction

    function automatic logic [W-1:0] encode_branch(input logic [1:0] cond,
                                                   input logic [3:0] ra,
                                                   input logic [18:0] imm);
        return {op_br, ra, cond, 2'b00, imm};
    endfunction

    function automatic logic [W-1:0] sign_extend(input logic [18:0] imm);
        return {{13{imm[18]}}, imm};
    endfunction

    function automatic logic [W-1:0] model_result(input opcode_e op, input logic [W-1:0] a,
                                                  input logic [W-1:0] b);
        logic [4:0] s;
        s = b[4:0];                            // shift amount from low five bits
        case (op)
            op_add, op_addi: return a + b;
            op_sub:          return a - b;
            op_and, op_andi: return a & b;
            op_or, op_ori:   return a | b;
            op_rotr:         return (a >> s) | (a << (32 - s));
            op_rotl:         return (a << s) | (a >> (32 - s));
            op_shr:          return a >> s;
            op_shra:         return $signed(a) >>> s;
            op_shl:          return a << s;
            op_neg:          return 32'd0 - b;
            op_not:          return ~b;
            default:         return '0;
        endcase
    endfunction

    function automatic logic branch_expected(input logic [1:0] cond, input logic [W-1:0] value);
        case (cond)
            2'd0:    return value == '0;
            2'd1:    return value != '0;
            2'd2:    return !value[W-1];
            default: return value[W-1];
        endcase
    endfunction

    task automatic check_value(input string name, input logic [W-1:0] expected,
                               input logic [W-1:0] actual);
        check_count++;
        if (actual !== expected)
        begin
            $display("FAILED %s: expected %h, got %h", name, expected, actual);
            error_count++;
        end
    endtask

    task automatic clear_memory();
        for (int i = 0; i < 256; i++)
            mem[i] <= fill_word(8'(i));
    endtask

    // pulse reset, check the idle state, then count cycles until halt
    task automatic run_program(input int instr_count, output int cycles);
        instr_budget = instr_budget + instr_count;
        @(posedge clock);
        #1 rst_n = 1'b0;
        repeat (3) @(posedge clock);
        #1 rst_n = 1'b1;
        check_value("halted", 32'd0, 32'(halted));
        check_value("mem_write", 32'd0, 32'(mem_write));
        check_value("mem_read", 32'd1, 32'(mem_read));    // first fetch reads memory
        check_value("mem_addr", `CPU_RESET_PC, mem_addr);
        cycles = 0;
        while (!halted)
        begin
            @(posedge clock);
            #1;
            cycles = cycles + 1;
        end
    endtask

    task automatic test_register_ops();
        opcode_e      ops [6] = '{op_add, op_sub, op_and, op_or, op_neg, op_not};
        logic [W-1:0] x;
        logic [W-1:0] y;
        int           cycles;
        x = $urandom();
        y = $urandom();
        clear_memory();
        mem[128] <= x;
        mem[129] <= y;
        mem[0]   <= encode_imm(op_ld, 4'd1, 4'd0, 19'd128);
        mem[1]   <= encode_imm(op_ld, 4'd2, 4'd0, 19'd129);
        for (int i = 0; i < 6; i++)
        begin
            mem[2 + 2 * i] <= encode_reg(ops[i], 4'd1, 4'd2, 4'd3);
            mem[3 + 2 * i] <= encode_imm(op_st, 4'd3, 4'd0, 19'(192 + i));
        end
        mem[14] <= halt_word;
        run_program(15, cycles);
        for (int i = 0; i < 6; i++)
            check_value($sformatf("mem[%0h] %s", 192 + i, ops[i].name()),
                        model_result(ops[i], x, y), mem[192 + i]);
    endtask

    task automatic test_immediates_and_shifts();
        opcode_e      imm_ops [3]   = '{op_addi, op_andi, op_ori};
        opcode_e      shift_ops [5] = '{op_rotr, op_rotl, op_shr, op_shra, op_shl};
        logic [W-1:0] v;
        logic [W-1:0] s;
        logic [18:0]  k;
        int           cycles;
        v = $urandom();
        s = $urandom();                        // upper bits must be ignored
        k = 19'($urandom());
        clear_memory();
        mem[128] <= v;
        mem[129] <= s;
        mem[0]   <= encode_imm(op_ld, 4'd1, 4'd0, 19'd128);
        mem[1]   <= encode_imm(op_ld, 4'd2, 4'd0, 19'd129);
        for (int i = 0; i < 3; i++)
        begin
            mem[2 + 2 * i] <= encode_imm(imm_ops[i], 4'd3, 4'd1, k);
            mem[3 + 2 * i] <= encode_imm(op_st, 4'd3, 4'd0, 19'(192 + i));
        end
        for (int i = 0; i < 5; i++)
        begin
            mem[8 + 2 * i] <= encode_reg(shift_ops[i], 4'd1, 4'd2, 4'd3);
            mem[9 + 2 * i] <= encode_imm(op_st, 4'd3, 4'd0, 19'(195 + i));
        end
        mem[18] <= encode_imm(op_ldi, 4'd4, 4'd0, k);
        mem[19] <= encode_imm(op_st, 4'd4, 4'd0, 19'd200);
        mem[20] <= encode_imm(op_addi, 4'd0, 4'd1, k);   // r0 must stay zero
        mem[21] <= encode_imm(op_st, 4'd0, 4'd0, 19'd201);
        mem[22] <= halt_word;
        run_program(23, cycles);
        for (int i = 0; i < 3; i++)
            check_value($sformatf("mem[%0h] %s", 192 + i, imm_ops[i].name()),
                        model_result(imm_ops[i], v, sign_extend(k)), mem[192 + i]);
        for (int i = 0; i < 5; i++)
            check_value($sformatf("mem[%0h] %s", 195 + i, shift_ops[i].name()),
                        model_result(shift_ops[i], v, s), mem[195 + i]);
        check_value("mem[c8] op_ldi", sign_extend(k), mem[200]);
        check_value("mem[c9] r0", 32'd0, mem[201]);
    endtask

    task automatic test_branches();
        logic [1:0]   conds [8] = '{2'd0, 2'd0, 2'd1, 2'd1, 2'd2, 2'd2, 2'd3, 2'd3};
        logic [3:0]   regs [8]  = '{4'd0, 4'd2, 4'd2, 4'd0, 4'd2, 4'd3, 4'd3, 4'd2};
        logic [W-1:0] reg_value [4];
        logic [W-1:0] expected;
        int           base;
        int           cycles;
        reg_value[0] = '0;
        reg_value[1] = '0;
        reg_value[2] = ($urandom() & 32'h7fff_ffff) | 32'h1;   // positive, nonzero
        reg_value[3] = $urandom() | 32'h8000_0000;
        clear_memory();
        mem[128] <= reg_value[2];
        mem[129] <= reg_value[3];
        mem[130] <= marker_skip;
        mem[131] <= marker_taken;
        for (int i = 0; i < 4; i++)
            mem[i] <= encode_imm(op_ld, (i < 2) ? 4'(i + 2) : 4'(i + 4), 4'd0, 19'(128 + i));
        for (int i = 0; i < 8; i++)
        begin
            base = 4 + 4 * i;
            mem[base]     <= encode_branch(conds[i], regs[i], 19'd2);
            mem[base + 1] <= encode_imm(op_st, 4'd6, 4'd0, 19'(192 + i));
            mem[base + 2] <= encode_branch(2'd0, 4'd0, 19'd1);     // always taken
            mem[base + 3] <= encode_imm(op_st, 4'd7, 4'd0, 19'(192 + i));
        end
        mem[36] <= halt_word;
        run_program(37, cycles);
        for (int i = 0; i < 8; i++)
        begin
            expected = branch_expected(conds[i], reg_value[regs[i]]) ? marker_taken : marker_skip;
            check_value($sformatf("mem[%0h] branch path", 192 + i), expected, mem[192 + i]);
        end
    endtask

    task automatic test_jumps();
        int cycles;
        clear_memory();
        mem[128] <= 32'd10;
        mem[129] <= 32'd20;
        mem[0]   <= encode_imm(op_ld, 4'd1, 4'd0, 19'd128);
        mem[1]   <= encode_imm(op_ld, 4'd2, 4'd0, 19'd129);
        mem[2]   <= encode_imm(op_jal, 4'd1, 4'd5, 19'd0);     // link into r5
        mem[3]   <= encode_imm(op_st, 4'd1, 4'd0, 19'd194);
        mem[4]   <= halt_word;
        mem[10]  <= encode_imm(op_st, 4'd5, 4'd0, 19'd192);
        mem[11]  <= encode_imm(op_jr, 4'd2, 4'd0, 19'd0);
        mem[12]  <= encode_imm(op_st, 4'd1, 4'd0, 19'd194);
        mem[13]  <= halt_word;
        mem[20]  <= encode_imm(op_st, 4'd2, 4'd0, 19'd193);
        mem[21]  <= halt_word;
        run_program(10, cycles);
        check_value("mem[c0] link", 32'd2 + 32'd1, mem[192]);  // jal address plus one
        check_value("mem[c1] jr target", 32'd20, mem[193]);
        check_value("mem[c2] skipped path", fill_word(8'hc2), mem[194]);
    endtask

    task automatic test_halt_timing();
        int count;
        int cycles;
        count = $urandom_range(6, 1);
        clear_memory();
        for (int i = 0; i < count; i++)
            mem[i] <= encode_imm(op_addi, 4'd1, 4'd1, 19'd1);
        mem[count] <= halt_word;
        run_program(count + 1, cycles);
        check_value("halt cycle", 32'(5 * count + 3), 32'(cycles));
    endtask

    initial
    begin
        clock        = 1'b0;
        rst_n        = 1'b0;
        error_count  = 0;
        check_count  = 0;
        cycle_count  = 0;
        instr_budget = 0;
        seed_value   = $urandom(59300);
        test_register_ops();
        test_immediates_and_shifts();
        test_branches();
        test_jumps();
        test_halt_timing();
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

// File: common/core_ctrl_pkg.sv
package core_ctrl_pkg;

    typedef enum logic [2:0] {
        ph_fetch      = 3'd0,
        ph_reg_read   = 3'd1,
        ph_execute    = 3'd2,
        ph_memory     = 3'd3,
        ph_write_back = 3'd4
    } phase_e;

    // mem and link values both pass through RY
    typedef enum logic [1:0] {
        res_alu  = 2'd0,
        res_mem  = 2'd1,
        res_link = 2'd2
    } result_src_e;

    typedef struct packed {
        logic                 ir_enable;
        logic                 pc_enable;
        logic                 pc_branch;    // pc from target instead of pc + 1
        logic                 ra_enable;
        logic                 rb_enable;
        logic                 rz_enable;
        logic                 rm_enable;
        logic                 ry_enable;
        logic                 rf_write;
        logic                 b_is_imm;
        logic                 addr_from_rz;
        logic                 mem_read;
        logic                 mem_write;
        result_src_e          result_src;
        isa_pkg::alu_op_e     alu_op;
    } ctrl_t;

endpackage

// File: common/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// one machine word
`define CPU_DATA_W 32

// r0 is hardwired to zero
`define CPU_REG_COUNT 16

`define CPU_RESET_PC 32'd0

`endif

// File: common/isa_pkg.sv
package isa_pkg;

    typedef enum logic [4:0] {
        op_ld   = 5'd0,
        op_ldi  = 5'd1,
        op_st   = 5'd2,
        op_add  = 5'd3,
        op_sub  = 5'd4,
        op_and  = 5'd5,
        op_or   = 5'd6,
        op_rotr = 5'd7,
        op_rotl = 5'd8,
        op_shr  = 5'd9,
        op_shra = 5'd10,
        op_shl  = 5'd11,
        op_addi = 5'd12,
        op_andi = 5'd13,
        op_ori  = 5'd14,
        op_neg  = 5'd17,
        op_not  = 5'd18,
        op_br   = 5'd19,
        op_jr   = 5'd20,
        op_jal  = 5'd21,
        op_halt = 5'd27
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_rotr,
        alu_rotl,
        alu_shr,
        alu_shra,
        alu_shl,
        alu_neg,
        alu_not,
        alu_pass_b
    } alu_op_e;

    typedef enum logic [1:0] {
        cond_zero     = 2'd0,
        cond_nonzero  = 2'd1,
        cond_positive = 2'd2,
        cond_negative = 2'd3
    } branch_cond_e;

    // instruction field positions
    localparam int opc_msb  = 31;
    localparam int opc_lsb  = 27;
    localparam int ra_msb   = 26;
    localparam int ra_lsb   = 23;
    localparam int rb_msb   = 22;
    localparam int rb_lsb   = 19;
    localparam int rc_msb   = 18;
    localparam int rc_lsb   = 15;
    localparam int cond_msb = 22;   // overlaps rb, branch only
    localparam int cond_lsb = 21;
    localparam int imm_msb  = 18;
    localparam int imm_lsb  = 0;
    localparam int imm_w    = imm_msb - imm_lsb + 1;

endpackage

// File: control/control_unit.sv
`include "cpu_params.svh"

module control_unit (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic [`CPU_DATA_W-1:0] ir,
    input  logic                   ra_zero,
    input  logic                   ra_negative,
    output core_ctrl_pkg::ctrl_t   ctrl,
    output logic                   halted
);
    import isa_pkg::*;
    import core_ctrl_pkg::*;

    phase_e       phase;
    opcode_e      opcode;
    branch_cond_e cond;
    logic         branch_taken;
    logic         uses_imm;
    logic         uses_alu;
    logic         writes_rf;

    assign opcode = opcode_e'(ir[opc_msb:opc_lsb]);
    assign cond   = branch_cond_e'(ir[cond_msb:cond_lsb]);

    assign uses_imm  = opcode inside {op_ld, op_ldi, op_st, op_addi, op_andi, op_ori, op_br};
    assign writes_rf = opcode inside {op_ld, op_ldi, op_add, op_sub, op_and, op_or, op_rotr,
                                      op_rotl, op_shr, op_shra, op_shl, op_addi, op_andi,
                                      op_ori, op_neg, op_not, op_jal};
    assign uses_alu  = writes_rf && (opcode != op_jal) || (opcode inside {op_st, op_br});

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            phase  <= ph_fetch;
            halted <= 1'b0;
        end
        else if (!halted)
        begin
            case (phase)
                ph_fetch:      phase <= ph_reg_read;
                ph_reg_read:   phase <= ph_execute;
                ph_execute:
                begin
                    if (opcode == op_halt)
                        halted <= 1'b1;         // parks in execute
                    else
                        phase <= ph_memory;
                end
                ph_memory:     phase <= ph_write_back;
                default:       phase <= ph_fetch;
            endcase
        end
    end

    // flags were captured from ra in reg_read
    always_comb
    begin
        case (cond)
            cond_zero:     branch_taken = ra_zero;
            cond_nonzero:  branch_taken = !ra_zero;
            cond_positive: branch_taken = !ra_negative;   // sign bit clear
            default:       branch_taken = ra_negative;
        endcase
    end

    always_comb
    begin
        ctrl            = '0;
        ctrl.b_is_imm   = uses_imm;
        ctrl.result_src = (opcode == op_ld)  ? res_mem  :
                          (opcode == op_jal) ? res_link : res_alu;
        case (opcode)
            op_add, op_addi, op_ld, op_ldi, op_st, op_br: ctrl.alu_op = alu_add;
            op_sub:            ctrl.alu_op = alu_sub;
            op_and, op_andi:   ctrl.alu_op = alu_and;
            op_or, op_ori:     ctrl.alu_op = alu_or;
            op_rotr:           ctrl.alu_op = alu_rotr;
            op_rotl:           ctrl.alu_op = alu_rotl;
            op_shr:            ctrl.alu_op = alu_shr;
            op_shra:           ctrl.alu_op = alu_shra;
            op_shl:            ctrl.alu_op = alu_shl;
            op_neg:            ctrl.alu_op = alu_neg;
            op_not:            ctrl.alu_op = alu_not;
            default:           ctrl.alu_op = alu_pass_b;
        endcase

        case (phase)
            ph_fetch:
            begin
                ctrl.ir_enable = 1'b1;
                ctrl.pc_enable = 1'b1;
                ctrl.mem_read  = 1'b1;
            end
            ph_reg_read:
            begin
                ctrl.ra_enable = 1'b1;
                ctrl.rb_enable = 1'b1;
                ctrl.rm_enable = 1'b1;
            end
            ph_execute:    ctrl.rz_enable = uses_alu;
            ph_memory:
            begin
                case (opcode)
                    op_ld:
                    begin
                        ctrl.mem_read     = 1'b1;
                        ctrl.addr_from_rz = 1'b1;
                        ctrl.ry_enable    = 1'b1;
                    end
                    op_st:
                    begin
                        ctrl.mem_write    = 1'b1;
                        ctrl.addr_from_rz = 1'b1;
                    end
                    op_br:
                    begin
                        ctrl.pc_enable = branch_taken;
                        ctrl.pc_branch = branch_taken;
                    end
                    op_jr:
                    begin
                        ctrl.pc_enable = 1'b1;
                        ctrl.pc_branch = 1'b1;
                    end
                    op_jal:
                    begin
                        ctrl.ry_enable = 1'b1;      // link captured before pc moves
                        ctrl.pc_enable = 1'b1;
                        ctrl.pc_branch = 1'b1;
                    end
                    default: ;
                endcase
            end
            ph_write_back: ctrl.rf_write = writes_rf;
            default: ;
        endcase
    end

endmodule

// File: datapath/alu.sv
`include "cpu_params.svh"

module alu (
    input  logic [`CPU_DATA_W-1:0] a,
    input  logic [`CPU_DATA_W-1:0] b,
    input  isa_pkg::alu_op_e       op,
    output logic [`CPU_DATA_W-1:0] result
);
    import isa_pkg::*;

    localparam int W = `CPU_DATA_W;

    logic [4:0]     amount;
    logic [2*W-1:0] rot_right;
    logic [2*W-1:0] rot_left;

    assign amount = b[4:0];

    // doubled word makes rotates plain shifts
    assign rot_right = {a, a} >> amount;
    assign rot_left  = {a, a} << amount;

    always_comb
    begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_and:  result = a & b;
            alu_or:   result = a | b;
            alu_rotr: result = rot_right[W-1:0];
            alu_rotl: result = rot_left[2*W-1:W];
            alu_shr:  result = a >> amount;
            alu_shra: result = $signed(a) >>> amount;   // sign fill
            alu_shl:  result = a << amount;
            alu_neg:  result = '0 - b;
            alu_not:  result = ~b;
            default:  result = b;                       // pass_b
        endcase
    end

endmodule

// File: datapath/datapath.sv
`include "cpu_params.svh"

module datapath (
    input  logic                   clock,
    input  logic                   rst_n,
    input  core_ctrl_pkg::ctrl_t   ctrl,
    input  logic [`CPU_DATA_W-1:0] mem_rdata,
    output logic [`CPU_DATA_W-1:0] ir,
    output logic                   ra_zero,
    output logic                   ra_negative,
    output logic [`CPU_DATA_W-1:0] mem_addr,
    output logic [`CPU_DATA_W-1:0] mem_wdata
);
    import isa_pkg::*;
    import core_ctrl_pkg::*;

    localparam int W  = `CPU_DATA_W;
    localparam int AW = $clog2(`CPU_REG_COUNT);

    opcode_e       opcode;
    logic [W-1:0]  pc;
    logic [W-1:0]  ra_q;
    logic [W-1:0]  rb_q;
    logic [W-1:0]  rz_q;
    logic [W-1:0]  rm_q;
    logic [W-1:0]  ry_q;
    logic [W-1:0]  imm_ext;
    logic [W-1:0]  alu_a;
    logic [W-1:0]  alu_b;
    logic [W-1:0]  alu_result;
    logic [W-1:0]  rf_a;
    logic [W-1:0]  rf_b;
    logic [W-1:0]  wb_data;
    logic [W-1:0]  pc_target;
    logic [AW-1:0] wr_addr;

    assign opcode  = opcode_e'(ir[opc_msb:opc_lsb]);
    assign imm_ext = {{(W - imm_w){ir[imm_msb]}}, ir[imm_msb:imm_lsb]};

    // br adds to pc, immediate forms use rb as base
    assign alu_a = (opcode == op_br) ? pc   :
                   ctrl.b_is_imm     ? rb_q : ra_q;
    assign alu_b = ctrl.b_is_imm ? imm_ext : rb_q;

    assign pc_target = (opcode == op_br) ? rz_q : ra_q;    // jr and jal go to ra
    assign wb_data   = (ctrl.result_src == res_alu) ? rz_q : ry_q;

    always_comb
    begin
        case (opcode)
            op_jal:                                     wr_addr = ir[rb_msb:rb_lsb];
            op_ld, op_ldi, op_addi, op_andi, op_ori:    wr_addr = ir[ra_msb:ra_lsb];
            default:                                    wr_addr = ir[rc_msb:rc_lsb];
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            pc <= `CPU_RESET_PC;
            ir <= '0;
        end
        else
        begin
            if (ctrl.pc_enable)
                pc <= ctrl.pc_branch ? pc_target : pc + 1'b1;
            if (ctrl.ir_enable)
                ir <= mem_rdata;
        end
    end

    always_ff @(posedge clock)
    begin
        if (ctrl.ra_enable)
        begin
            ra_q        <= rf_a;
            ra_zero     <= (rf_a == '0);
            ra_negative <= rf_a[W-1];
        end
        if (ctrl.rb_enable)
            rb_q <= rf_b;
        if (ctrl.rm_enable)
            rm_q <= rf_a;                   // store data
        if (ctrl.rz_enable)
            rz_q <= alu_result;
        if (ctrl.ry_enable)
            ry_q <= (ctrl.result_src == res_link) ? pc : mem_rdata;
    end

    assign mem_addr  = ctrl.addr_from_rz ? rz_q : pc;
    assign mem_wdata = rm_q;

    alu u_alu (
        .a      (alu_a),
        .b      (alu_b),
        .op     (ctrl.alu_op),
        .result (alu_result)
    );

    register_file u_register_file (
        .clock        (clock),
        .rst_n        (rst_n),
        .read_addr_a  (ir[ra_msb:ra_lsb]),
        .read_addr_b  (ir[rb_msb:rb_lsb]),
        .write_addr   (wr_addr),
        .write_data   (wb_data),
        .write_enable (ctrl.rf_write),
        .read_data_a  (rf_a),
        .read_data_b  (rf_b)
    );

endmodule

// File: datapath/register_file.sv
`include "cpu_params.svh"

module register_file (
    input  logic                               clock,
    input  logic                               rst_n,
    input  logic [$clog2(`CPU_REG_COUNT)-1:0] read_addr_a,
    input  logic [$clog2(`CPU_REG_COUNT)-1:0] read_addr_b,
    input  logic [$clog2(`CPU_REG_COUNT)-1:0] write_addr,
    input  logic [`CPU_DATA_W-1:0]            write_data,
    input  logic                               write_enable,
    output logic [`CPU_DATA_W-1:0]            read_data_a,
    output logic [`CPU_DATA_W-1:0]            read_data_b
);

    logic [`CPU_DATA_W-1:0] regs [`CPU_REG_COUNT];

    always_ff @(posedge clock)
    begin
        if (!rst_n)
        begin
            for (int i = 0; i < `CPU_REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (write_enable && (write_addr != '0))    // r0 stays zero
        begin
            regs[write_addr] <= write_data;
        end
    end

    assign read_data_a = (read_addr_a == '0) ? '0 : regs[read_addr_a];
    assign read_data_b = (read_addr_b == '0) ? '0 : regs[read_addr_b];

endmodule

// File: src/cpu_top.sv
`include "cpu_params.svh"

module cpu_top (
    input  logic                   clock,
    input  logic                   rst_n,
    input  logic [`CPU_DATA_W-1:0] mem_rdata,
    output logic [`CPU_DATA_W-1:0] mem_addr,
    output logic [`CPU_DATA_W-1:0] mem_wdata,
    output logic                   mem_read,
    output logic                   mem_write,
    output logic                   halted
);
    import core_ctrl_pkg::*;

    ctrl_t                  ctrl;
    logic [`CPU_DATA_W-1:0] ir;
    logic                   ra_zero;
    logic                   ra_negative;

    assign mem_read  = ctrl.mem_read;
    assign mem_write = ctrl.mem_write;

    control_unit u_control_unit (
        .clock       (clock),
        .rst_n       (rst_n),
        .ir          (ir),
        .ra_zero     (ra_zero),
        .ra_negative (ra_negative),
        .ctrl        (ctrl),
        .halted      (halted)
    );

    datapath u_datapath (
        .clock       (clock),
        .rst_n       (rst_n),
        .ctrl        (ctrl),
        .mem_rdata   (mem_rdata),
        .ir          (ir),
        .ra_zero     (ra_zero),
        .ra_negative (ra_negative),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata)
    );

endmodule
